/* hdl/collectPkg.sv */
package collectPkg;

    // address split
    localparam int ADDR_WIDTH = 12;
    localparam int BANK_ADDR_WIDTH = 10;

    // entry layout
    localparam int SLOT_COUNT = 6;
    localparam int SLOT_WIDTH = 10;
    localparam int ENTRY_WIDTH = SLOT_COUNT * SLOT_WIDTH;
    localparam int SUB_ADDR_WIDTH = 3;

    // slot encoding of low exponent bits, offset tag and check nibble
    localparam int EXP_WIDTH = 6;
    localparam int TAG_LSB = 4;
    localparam int TAG_WIDTH = EXP_WIDTH - TAG_LSB;
    localparam logic [SLOT_WIDTH-EXP_WIDTH-1:0] CHECK_NIBBLE = '0;

    // result widths
    localparam int PCOEFF_WIDTH = 36;
    localparam int SUM_WIDTH = 38;
    localparam int COUNT_WIDTH = 3;

    // read path latency
    localparam int READ_LATENCY = 8;
    localparam int RAM_CYCLES = 3;

    typedef logic [SUM_WIDTH-1:0] sumT;
    typedef logic [COUNT_WIDTH-1:0] countT;
    typedef logic [ENTRY_WIDTH-1:0] entryT;

endpackage

/* hdl/maskedDualPortRam.sv */
`timescale 1ns/1ps

module maskedDualPortRam (
    input  logic                                  clk,
    input  logic                                  writeEnable,
    input  logic [collectPkg::BANK_ADDR_WIDTH-1:0] writeAddr,
    input  logic [1:0]                            writeMask,
    input  logic [2*collectPkg::SLOT_WIDTH-1:0]    writeData,
    input  logic                                  readEnable,
    input  logic [collectPkg::BANK_ADDR_WIDTH-1:0] readAddr,
    output logic [2*collectPkg::SLOT_WIDTH-1:0]    readData
);

    localparam int HALF = collectPkg::SLOT_WIDTH;
    localparam int DEPTH = 1 << collectPkg::BANK_ADDR_WIDTH;

    logic [2*HALF-1:0] mem [DEPTH];
    logic [collectPkg::BANK_ADDR_WIDTH-1:0] readAddrQ;
    logic readEnableQ;

    // block RAM powers up cleared
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // each half has its own byte-enable style mask bit
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            if (writeMask[0]) begin
                mem[writeAddr][HALF-1:0] <= writeData[HALF-1:0];
            end
            if (writeMask[1]) begin
                mem[writeAddr][2*HALF-1:HALF] <= writeData[2*HALF-1:HALF];
            end
        end
    end

    // input register, then output register
    always_ff @(posedge clk) begin
        readAddrQ <= readAddr;
        readEnableQ <= readEnable;
        // zero when idle so banks can be ORed
        readData <= readEnableQ ? mem[readAddrQ] : '0;
    end

endmodule

/* hdl/collectorBlock.sv */
`timescale 1ns/1ps

module collectorBlock (
    input  logic                                  clk,
    input  logic                                  arstN,
    input  logic                                  writeEnable,
    input  logic [collectPkg::BANK_ADDR_WIDTH-1:0] writeAddr,
    input  logic [collectPkg::SLOT_COUNT-1:0]      subAddrMask,
    input  logic [collectPkg::SLOT_WIDTH-1:0]      writeData,
    input  logic                                  readEnable,
    input  logic [collectPkg::BANK_ADDR_WIDTH-1:0] readAddr,
    output collectPkg::entryT                     readData
);

    localparam int SW = collectPkg::SLOT_WIDTH;
    localparam int RAM_COUNT = collectPkg::SLOT_COUNT / 2;

    logic blockWrite;
    logic [collectPkg::BANK_ADDR_WIDTH-1:0] blockWriteAddr;
    logic [collectPkg::SLOT_COUNT-1:0] blockWriteMask;
    logic [SW-1:0] blockWriteData;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            blockWrite <= 1'b0;
        end else begin
            blockWrite <= writeEnable | readEnable;
        end
    end

    // a read wins and clears the whole entry it just fetched
    always_ff @(posedge clk) begin
        blockWriteAddr <= readEnable ? readAddr : writeAddr;
        blockWriteMask <= readEnable ? '1 : subAddrMask;
        blockWriteData <= readEnable ? '0 : writeData;
    end

    // two slots per RAM with the slot word on both halves
    for (genvar r = 0; r < RAM_COUNT; r++) begin : genRam
        maskedDualPortRam ram (
            .clk        (clk),
            .writeEnable(blockWrite),
            .writeAddr  (blockWriteAddr),
            .writeMask  (blockWriteMask[2*r+1:2*r]),
            .writeData  ({blockWriteData, blockWriteData}),
            .readEnable (readEnable),
            .readAddr   (readAddr),
            .readData   (readData[2*SW*r +: 2*SW])
        );
    end

endmodule

/* hdl/delayPipe.sv */
`timescale 1ns/1ps

module delayPipe #(
    parameter type dataT = logic,
    parameter int CYCLES = 1
) (
    input  logic clk,
    input  logic arstN,
    input  dataT dataIn,
    output dataT dataOut
);

    dataT stage [CYCLES];

    // plain shift chain free for retiming into the logic in front
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < CYCLES; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= dataIn;
            for (int i = 1; i < CYCLES; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dataOut = stage[CYCLES-1];

endmodule

/* hdl/pcoeffSummer.sv */
`timescale 1ns/1ps

module pcoeffSummer (
    input  logic                               clk,
    input  collectPkg::entryT                  entryIn,
    output logic [collectPkg::PCOEFF_WIDTH:0]   sum01,
    output logic [collectPkg::PCOEFF_WIDTH:0]   sum23,
    output logic [collectPkg::PCOEFF_WIDTH:0]   sum45,
    output collectPkg::countT                  validCount
);

    localparam int SC = collectPkg::SLOT_COUNT;
    localparam int SW = collectPkg::SLOT_WIDTH;
    localparam int PW = collectPkg::PCOEFF_WIDTH;
    localparam int EW = collectPkg::EXP_WIDTH;
    localparam int TL = collectPkg::TAG_LSB;
    localparam int TW = collectPkg::TAG_WIDTH;

    logic [EW-1:0] exponent [SC];
    logic slotValid [SC];
    logic slotValidQ [SC];
    logic slotValidQQ [SC];
    logic [PW-1:0] pcoeff [SC];

    for (genvar s = 0; s < SC; s++) begin : genSlot
        logic [TW-1:0] tag;

        assign tag = entryIn[s*SW+TL +: TW];

        always_ff @(posedge clk) begin
            // tag holds the exponent high bits plus one
            exponent[s] <= {tag - TW'(1), entryIn[s*SW +: TL]};
            slotValid[s] <= tag != '0;
            // exponents past 35 fall off the top
            pcoeff[s] <= slotValid[s] ? PW'(1) << exponent[s] : '0;
            slotValidQ[s] <= slotValid[s];
            slotValidQQ[s] <= slotValidQ[s];
        end
    end

    // first level of the adder tree
    always_ff @(posedge clk) begin
        sum01 <= {1'b0, pcoeff[0]} + {1'b0, pcoeff[1]};
        sum23 <= {1'b0, pcoeff[2]} + {1'b0, pcoeff[3]};
        sum45 <= {1'b0, pcoeff[4]} + {1'b0, pcoeff[5]};
    end

    // count lines up with the pair sums
    always_comb begin
        validCount = '0;
        for (int s = 0; s < SC; s++) begin
            validCount = validCount + collectPkg::countT'(slotValidQQ[s]);
        end
    end

endmodule

/* hdl/collectionModule.sv */
`timescale 1ns/1ps

module collectionModule #(
    parameter int ADDR_WIDTH = collectPkg::ADDR_WIDTH
) (
    input  logic                                 clk,
    input  logic                                 arstN,
    input  logic                                 write,
    input  logic [ADDR_WIDTH-1:0]                dataInAddr,
    input  logic [collectPkg::SUB_ADDR_WIDTH-1:0] dataInSubAddr,
    input  logic [collectPkg::EXP_WIDTH-1:0]      addBit,
    input  logic                                 read,
    input  logic [ADDR_WIDTH-1:0]                readAddr,
    output logic                                 outValid,
    output collectPkg::sumT                      summedDataOut,
    output collectPkg::countT                    pcoeffCount
);

    localparam int SC = collectPkg::SLOT_COUNT;
    localparam int SW = collectPkg::SLOT_WIDTH;
    localparam int PW = collectPkg::PCOEFF_WIDTH;
    localparam int TL = collectPkg::TAG_LSB;
    localparam int TW = collectPkg::TAG_WIDTH;
    localparam int EW = collectPkg::EXP_WIDTH;
    localparam int BAW = collectPkg::BANK_ADDR_WIDTH;
    localparam int BANK_SEL_WIDTH = ADDR_WIDTH - BAW;
    localparam int BANK_COUNT = 1 << BANK_SEL_WIDTH;
    // pcoeff and pair-sum registers sit between the RAM cycles and the pipes
    localparam int PIPE_CYCLES = collectPkg::READ_LATENCY - collectPkg::RAM_CYCLES - 2;

    logic [SC-1:0] subAddrMask;
    logic [SW-1:0] slotWord;
    collectPkg::entryT bankReadData [BANK_COUNT];
    collectPkg::entryT orReadData;
    logic [PW:0] sum01;
    logic [PW:0] sum23;
    logic [PW:0] sum45;
    collectPkg::sumT sumPrePipe;
    collectPkg::countT countPrePipe;

    assign subAddrMask = SC'(1) << dataInSubAddr;

    // tag of zero means empty so the high bits are stored offset by one
    assign slotWord = {collectPkg::CHECK_NIBBLE, addBit[EW-1:TL] + TW'(1), addBit[TL-1:0]};

    for (genvar b = 0; b < BANK_COUNT; b++) begin : genBank
        collectorBlock bank (
            .clk        (clk),
            .arstN      (arstN),
            .writeEnable(write && dataInAddr[ADDR_WIDTH-1:BAW] == BANK_SEL_WIDTH'(b)),
            .writeAddr  (dataInAddr[BAW-1:0]),
            .subAddrMask(subAddrMask),
            .writeData  (slotWord),
            .readEnable (read && readAddr[ADDR_WIDTH-1:BAW] == BANK_SEL_WIDTH'(b)),
            .readAddr   (readAddr[BAW-1:0]),
            .readData   (bankReadData[b])
        );
    end

    // idle banks return zero
    always_comb begin
        orReadData = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            orReadData = orReadData | bankReadData[b];
        end
    end

    pcoeffSummer summer (
        .clk       (clk),
        .entryIn   (orReadData),
        .sum01     (sum01),
        .sum23     (sum23),
        .sum45     (sum45),
        .validCount(countPrePipe)
    );

    // final add that the pipe registers get pushed back into
    assign sumPrePipe = collectPkg::sumT'(sum01) + collectPkg::sumT'(sum23)
                      + collectPkg::sumT'(sum45);

    delayPipe #(.dataT(collectPkg::sumT), .CYCLES(PIPE_CYCLES)) sumPipe (
        .clk    (clk),
        .arstN  (arstN),
        .dataIn (sumPrePipe),
        .dataOut(summedDataOut)
    );

    delayPipe #(.dataT(collectPkg::countT), .CYCLES(PIPE_CYCLES)) countPipe (
        .clk    (clk),
        .arstN  (arstN),
        .dataIn (countPrePipe),
        .dataOut(pcoeffCount)
    );

    delayPipe #(.dataT(logic), .CYCLES(collectPkg::READ_LATENCY)) validPipe (
        .clk    (clk),
        .arstN  (arstN),
        .dataIn (read),
        .dataOut(outValid)
    );

endmodule

/* sim/collectionModule_properties.sv */
`timescale 1ns/1ps

module collectionModuleProperties (
    input logic                                  clk,
    input logic                                  arstN,
    input logic                                  write,
    input logic [collectPkg::SUB_ADDR_WIDTH-1:0] dataInSubAddr,
    input logic                                  read,
    input logic                                  outValid,
    input collectPkg::countT                     pcoeffCount
);

    // pipes are cleared while reset is held
    assert property (@(posedge clk) !arstN |-> !outValid)
        else $error("outValid high during reset");

    assert property (@(posedge clk) disable iff (!arstN)
        read |-> ##(collectPkg::READ_LATENCY) outValid)
        else $error("outValid missing after a read");

    assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> $past(read, collectPkg::READ_LATENCY))
        else $error("outValid without a matching read");

    assert property (@(posedge clk) disable iff (!arstN)
        pcoeffCount <= collectPkg::countT'(collectPkg::SLOT_COUNT))
        else $error("pcoeffCount above the slot count");

    assert property (@(posedge clk) disable iff (!arstN)
        write |-> dataInSubAddr < collectPkg::SLOT_COUNT)
        else $error("write with sub-address out of range");

endmodule

bind collectionModule collectionModuleProperties props (
    .clk          (clk),
    .arstN        (arstN),
    .write        (write),
    .dataInSubAddr(dataInSubAddr),
    .read         (read),
    .outValid     (outValid),
    .pcoeffCount  (pcoeffCount)
);

/* sim/collectionTb.sv */
`timescale 1ns/1ps

module collectionTb;

    localparam int AW = 12;
    localparam int RESET_CYCLES = 5;
    localparam int RANDOM_OPS = 96;
    localparam int SWEEP_READS = 32;
    localparam int LAT = collectPkg::READ_LATENCY;

    typedef enum {IDLE, WRITE, READ, BOTH} opT;
    typedef struct {
        string name;
        opT op;
        logic [AW-1:0] wrAddr;
        logic [2:0] sub;
        logic [5:0] bits;
        logic [AW-1:0] rdAddr;
        collectPkg::sumT expSum;
        collectPkg::countT expCount;
    } rowT;

    logic clk;
    logic arstN;
    logic write;
    logic [AW-1:0] dataInAddr;
    logic [2:0] dataInSubAddr;
    logic [5:0] addBit;
    logic read;
    logic [AW-1:0] readAddr;
    logic outValid;
    collectPkg::sumT summedDataOut;
    collectPkg::countT pcoeffCount;

    rowT rows[$];
    // exponent code per key of address * 8 + slot
    int modelSlot [int];
    collectPkg::sumT sumQ[$];
    collectPkg::countT countQ[$];
    int stampQ[$];
    string nameQ[$];
    int edgeCount = 0;
    int cycleLimit;
    int issuedReads = 0;
    int checkedReads = 0;
    logic [15:0] lfsr = 16'd13417;

    collectionModule #(.ADDR_WIDTH(AW)) u_dut (
        .clk(clk), .arstN(arstN), .write(write), .dataInAddr(dataInAddr),
        .dataInSubAddr(dataInSubAddr), .addBit(addBit), .read(read), .readAddr(readAddr),
        .outValid(outValid), .summedDataOut(summedDataOut), .pcoeffCount(pcoeffCount)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        edgeCount <= edgeCount + 1;
        if (edgeCount > cycleLimit) begin
            failRun($sformatf("timeout after %0d cycles", edgeCount));
        end
    end

    function automatic logic [15:0] galoisStep(input logic [15:0] state);
        // taps 16 14 13 11
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic drawBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr = galoisStep(lfsr);
        end
    endtask

    function automatic logic [AW-1:0] randomAddr(input int sel);
        // eight entries in each of the four banks
        return {2'(sel >> 3), 7'h40, 3'(sel)};
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkSum(input string name, input collectPkg::sumT expected,
                            input collectPkg::sumT actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch %s sum expected 0x%0h actual 0x%0h",
                              name, expected, actual));
        end
    endtask

    task automatic checkCount(input string name, input collectPkg::countT expected,
                              input collectPkg::countT actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch %s count expected %0d actual %0d",
                              name, expected, actual));
        end
    endtask

    task automatic checkValid(input string name, input int expected, input int actual);
        if (actual != expected) begin
            failRun($sformatf("mismatch %s latency expected %0d actual %0d",
                              name, expected, actual));
        end
    endtask

    task automatic addRow(input string name, input opT op, input logic [AW-1:0] wrAddr,
                          input logic [2:0] sub, input logic [5:0] bits,
                          input logic [AW-1:0] rdAddr, input collectPkg::sumT expSum,
                          input collectPkg::countT expCount);
        rows.push_back('{name, op, wrAddr, sub, bits, rdAddr, expSum, expCount});
    endtask

    task automatic readModel(input logic [AW-1:0] addr, output collectPkg::sumT sum,
                             output collectPkg::countT count);
        int key;
        sum = '0;
        count = '0;
        for (int s = 0; s < collectPkg::SLOT_COUNT; s++) begin
            key = int'(addr) * 8 + s;
            // codes 48 to 63 wrap the tag to zero and read as empty
            if (modelSlot.exists(key) && modelSlot[key] < 48) begin
                count = count + 1'b1;
                if (modelSlot[key] < collectPkg::PCOEFF_WIDTH) begin
                    sum = sum + collectPkg::sumT'(64'd1 << modelSlot[key]);
                end
            end
            modelSlot.delete(key);
        end
    endtask

    task automatic driveOp(input opT op, input string name, input logic [AW-1:0] wrAddr,
                           input logic [2:0] sub, input logic [5:0] bits,
                           input logic [AW-1:0] rdAddr, output collectPkg::sumT modelSum,
                           output collectPkg::countT modelCount);
        logic doWrite;
        logic doRead;
        doWrite = op inside {WRITE, BOTH};
        doRead = op inside {READ, BOTH};
        write <= doWrite;
        dataInAddr <= wrAddr;
        dataInSubAddr <= sub;
        addBit <= bits;
        read <= doRead;
        readAddr <= rdAddr;
        modelSum = '0;
        modelCount = '0;
        if (doRead) begin
            readModel(rdAddr, modelSum, modelCount);
            sumQ.push_back(modelSum);
            countQ.push_back(modelCount);
            stampQ.push_back(edgeCount);
            nameQ.push_back(name);
            issuedReads++;
        end
        // a read in the same bank takes the write port
        if (doWrite && !(doRead && wrAddr[AW-1:10] == rdAddr[AW-1:10])) begin
            modelSlot[int'(wrAddr) * 8 + int'(sub)] = int'(bits);
        end
    endtask

    task automatic buildTable();
        addRow("write e0", WRITE, 12'h005, 3'd0, 6'd0, '0, '0, '0);
        addRow("single e0", READ, '0, '0, '0, 12'h005, 38'h1, 3'd1);
        addRow("write e35", WRITE, 12'h006, 3'd3, 6'd35, '0, '0, '0);
        addRow("single e35", READ, '0, '0, '0, 12'h006, 38'h8_0000_0000, 3'd1);
        addRow("write e47", WRITE, 12'h007, 3'd5, 6'd47, '0, '0, '0);
        addRow("single e47", READ, '0, '0, '0, 12'h007, 38'h0, 3'd1);
        addRow("write e48", WRITE, 12'h008, 3'd1, 6'd48, '0, '0, '0);
        addRow("write e63", WRITE, 12'h008, 3'd2, 6'd63, '0, '0, '0);
        addRow("empty codes", READ, '0, '0, '0, 12'h008, 38'h0, 3'd0);
        addRow("fill 0", WRITE, 12'h010, 3'd0, 6'd1, '0, '0, '0);
        addRow("fill 1", WRITE, 12'h010, 3'd1, 6'd2, '0, '0, '0);
        addRow("fill 2", WRITE, 12'h010, 3'd2, 6'd33, '0, '0, '0);
        addRow("fill 3", WRITE, 12'h010, 3'd3, 6'd10, '0, '0, '0);
        addRow("fill 4", WRITE, 12'h010, 3'd4, 6'd20, '0, '0, '0);
        addRow("fill 5", WRITE, 12'h010, 3'd5, 6'd30, '0, '0, '0);
        addRow("refill 2", WRITE, 12'h010, 3'd2, 6'd3, '0, '0, '0);
        addRow("full entry", READ, '0, '0, '0, 12'h010, 38'h4010_040E, 3'd6);
        addRow("gap", IDLE, '0, '0, '0, '0, '0, '0);
        addRow("wiped entry", READ, '0, '0, '0, 12'h010, 38'h0, 3'd0);
        addRow("rewrite", WRITE, 12'h010, 3'd4, 6'd12, '0, '0, '0);
        addRow("rewrite read", READ, '0, '0, '0, 12'h010, 38'h1000, 3'd1);
        addRow("bank0 write", WRITE, 12'h020, 3'd0, 6'd4, '0, '0, '0);
        addRow("bank1 write", WRITE, 12'h420, 3'd0, 6'd5, '0, '0, '0);
        addRow("bank2 write", WRITE, 12'h820, 3'd1, 6'd6, '0, '0, '0);
        addRow("bank3 write", WRITE, 12'hC20, 3'd0, 6'd7, '0, '0, '0);
        addRow("bank0 read", READ, '0, '0, '0, 12'h020, 38'h10, 3'd1);
        addRow("bank1 read", READ, '0, '0, '0, 12'h420, 38'h20, 3'd1);
        addRow("bank2 read", READ, '0, '0, '0, 12'h820, 38'h40, 3'd1);
        addRow("bank3 read", READ, '0, '0, '0, 12'hC20, 38'h80, 3'd1);
        addRow("prefill", WRITE, 12'h030, 3'd0, 6'd9, '0, '0, '0);
        addRow("collide read", BOTH, 12'h031, 3'd0, 6'd11, 12'h030, 38'h200, 3'd1);
        addRow("dropped write", READ, '0, '0, '0, 12'h031, 38'h0, 3'd0);
        addRow("split banks", BOTH, 12'h432, 3'd1, 6'd13, 12'h031, 38'h0, 3'd0);
        addRow("other bank", READ, '0, '0, '0, 12'h432, 38'h2000, 3'd1);
    endtask

    always @(negedge clk) begin : monitor
        string name;
        int stamp;
        if (outValid === 1'b1) begin
            if (sumQ.size() == 0) begin
                failRun("outValid went high with no read outstanding");
            end else begin
                name = nameQ.pop_front();
                stamp = stampQ.pop_front();
                // stamp is taken before the driving edge is counted
                checkValid(name, LAT, edgeCount - stamp - 1);
                checkSum(name, sumQ.pop_front(), summedDataOut);
                checkCount(name, countQ.pop_front(), pcoeffCount);
                checkedReads++;
            end
        end
    end

    initial begin : stimulus
        collectPkg::sumT modelSum;
        collectPkg::countT modelCount;
        int opBits;
        int wrSel;
        int rdSel;
        int sub;
        int bits;
        clk = 1'b0;
        arstN = 1'b0;
        write = 1'b0;
        dataInAddr = '0;
        dataInSubAddr = '0;
        addBit = '0;
        read = 1'b0;
        readAddr = '0;
        buildTable();
        cycleLimit = RESET_CYCLES + rows.size() + RANDOM_OPS + SWEEP_READS + 2 * LAT + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;
        foreach (rows[i]) begin
            @(posedge clk);
            driveOp(rows[i].op, rows[i].name, rows[i].wrAddr, rows[i].sub, rows[i].bits,
                    rows[i].rdAddr, modelSum, modelCount);
            if (rows[i].op inside {READ, BOTH} &&
                (modelSum !== rows[i].expSum || modelCount !== rows[i].expCount)) begin
                failRun({"reference model disagrees with table row ", rows[i].name});
            end
        end
        for (int i = 0; i < RANDOM_OPS; i++) begin
            drawBits(2, opBits);
            drawBits(5, wrSel);
            drawBits(5, rdSel);
            drawBits(3, sub);
            drawBits(6, bits);
            @(posedge clk);
            driveOp(opT'(opBits), $sformatf("random %0d", i), randomAddr(wrSel),
                    3'(sub % 6), 6'(bits), randomAddr(rdSel), modelSum, modelCount);
        end
        // empty every entry the random traffic could have touched
        for (int i = 0; i < SWEEP_READS; i++) begin
            @(posedge clk);
            driveOp(READ, $sformatf("sweep %0d", i), '0, '0, '0, randomAddr(i),
                    modelSum, modelCount);
        end
        @(posedge clk);
        driveOp(IDLE, "idle", '0, '0, '0, '0, modelSum, modelCount);
        repeat (LAT + 2) @(posedge clk);
        if (checkedReads == issuedReads) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            failRun($sformatf("%0d reads issued but %0d answered", issuedReads, checkedReads));
        end
    end

endmodule

/* compile.f */
hdl/collectPkg.sv
hdl/maskedDualPortRam.sv
hdl/collectorBlock.sv
hdl/delayPipe.sv
hdl/pcoeffSummer.sv
hdl/collectionModule.sv
sim/collectionModule_properties.sv
sim/collectionTb.sv

/* Bender.yml */
package:
  name: collection_memory

sources:
  - hdl/collectPkg.sv
  - hdl/maskedDualPortRam.sv
  - hdl/collectorBlock.sv
  - hdl/delayPipe.sv
  - hdl/pcoeffSummer.sv
  - hdl/collectionModule.sv
  - target: simulation
    files:
      - sim/collectionModule_properties.sv
      - sim/collectionTb.sv
